// ==== logic/rob_pkg.sv ====
package rob_pkg;

	// Default tag width, eight entries.
	parameter int ROB_TAG_WIDTH_DEF = 3;

	// LC-3b instruction word encodings.
	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef logic [2:0] lc3b_reg;
	typedef logic [15:0] lc3b_word;

	// Result known at dispatch, no bus write needed.
	function automatic logic ready_at_alloc(input lc3b_opcode op);
		return (op inside {op_br, op_lea, op_jsr, op_str, op_stb});
	endfunction

	// Opcodes that update their dest at retire.
	function automatic logic writes_reg(input lc3b_opcode op);
		return (op inside {op_add, op_and, op_not, op_ldb, op_ldi, op_ldr, op_lea, op_shf,
			op_jsr});
	endfunction

endpackage

// ==== logic/rob_ifs.sv ====
interface dispatch_if #(parameter int rob_tag_width = rob_pkg::ROB_TAG_WIDTH_DEF);
	import rob_pkg::*;

	// Driven by the top level.
	logic valid;
	lc3b_opcode opcode;
	lc3b_reg dest;
	lc3b_word value;
	logic predict;
	lc3b_word pc;
	// Returned by the buffer.
	logic [rob_tag_width-1:0] tag;
	logic full;

	modport storage (input valid, opcode, dest, value, predict, pc, output tag, full);
	modport rename (input valid, opcode, dest, tag, full);
endinterface

interface retire_if #(parameter int rob_tag_width = rob_pkg::ROB_TAG_WIDTH_DEF);
	import rob_pkg::*;

	// Head entry view.
	logic head_valid;
	lc3b_opcode opcode;
	lc3b_reg dest;
	lc3b_word value;
	logic predict;
	lc3b_word pc;
	logic [rob_tag_width-1:0] head_tag;
	// Retire decisions.
	logic pop;
	logic commit_we;
	logic flush;

	modport storage (output head_valid, opcode, dest, value, predict, pc, head_tag,
		input pop, flush);
	modport ctrl (input head_valid, opcode, value, predict, pc, output pop, commit_we, flush);
	modport rename (input commit_we, dest, value, head_tag, flush);
endinterface

interface lookup_if #(parameter int rob_tag_width = rob_pkg::ROB_TAG_WIDTH_DEF);
	import rob_pkg::*;

	logic [rob_tag_width-1:0] sr1_tag;
	logic [rob_tag_width-1:0] sr2_tag;
	lc3b_word sr1_value;
	logic sr1_valid;
	lc3b_word sr2_value;
	logic sr2_valid;

	modport storage (input sr1_tag, sr2_tag, output sr1_value, sr1_valid, sr2_value, sr2_valid);
	modport rename (output sr1_tag, sr2_tag, input sr1_value, sr1_valid, sr2_value, sr2_valid);
endinterface

// ==== logic/rob_storage.sv ====
module rob_storage #(parameter int rob_tag_width = rob_pkg::ROB_TAG_WIDTH_DEF)
(
	input logic clk,
	input logic rst,
	dispatch_if.storage disp,
	retire_if.storage ret,
	lookup_if.storage lkp,
	input logic cdb_valid,
	input logic [rob_tag_width-1:0] cdb_tag,
	input rob_pkg::lc3b_word cdb_value
);
	import rob_pkg::*;

	localparam int entries = 2 ** rob_tag_width;

	// Entry payload fields.
	lc3b_opcode opcode_q [entries];
	lc3b_reg dest_q [entries];
	lc3b_word value_q [entries];
	logic predict_q [entries];
	lc3b_word pc_q [entries];
	// Result present flag per entry.
	logic [entries-1:0] valid_q;

	// Circular pointers, count one bit wider.
	logic [rob_tag_width-1:0] head;
	logic [rob_tag_width-1:0] tail;
	logic [rob_tag_width:0] count;

	logic empty;
	logic alloc;

	assign empty = (count == '0);
	assign disp.full = (count == entries[rob_tag_width:0]);
	assign disp.tag = tail;

	// Dispatch is ignored while full or in the flush cycle.
	assign alloc = disp.valid && !disp.full && !ret.flush;

	// Head entry.
	assign ret.head_valid = !empty && valid_q[head];
	assign ret.opcode = opcode_q[head];
	assign ret.dest = dest_q[head];
	assign ret.value = value_q[head];
	assign ret.predict = predict_q[head];
	assign ret.pc = pc_q[head];
	assign ret.head_tag = head;

	// Operand reads by tag.
	assign lkp.sr1_value = value_q[lkp.sr1_tag];
	assign lkp.sr1_valid = valid_q[lkp.sr1_tag];
	assign lkp.sr2_value = value_q[lkp.sr2_tag];
	assign lkp.sr2_valid = valid_q[lkp.sr2_tag];

	// Payload written at the tail.
	always_ff @(posedge clk)
	begin
		if (alloc)
		begin
			opcode_q[tail] <= disp.opcode;
			dest_q[tail] <= disp.dest;
			predict_q[tail] <= disp.predict;
			pc_q[tail] <= disp.pc;
			value_q[tail] <= disp.value;
		end
		// Bus results land by tag.
		if (cdb_valid)
			value_q[cdb_tag] <= cdb_value;
	end

	// Valid bits, pointers and count.
	always_ff @(posedge clk)
	begin
		if (rst || ret.flush)
		begin
			valid_q <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			if (alloc)
			begin
				valid_q[tail] <= ready_at_alloc(disp.opcode);
				tail <= tail + 1'b1;
			end
			if (cdb_valid)
				valid_q[cdb_tag] <= 1'b1;
			// Retired entry drops its valid.
			if (ret.pop)
			begin
				valid_q[head] <= 1'b0;
				head <= head + 1'b1;
			end
			// Allocate and pop together cancel.
			case ({alloc, ret.pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== logic/retire_ctrl.sv ====
module retire_ctrl
(
	input logic clk,
	input logic rst,
	retire_if.ctrl ret,
	output logic mispredict,
	output rob_pkg::lc3b_word mispredict_pc
);
	import rob_pkg::*;

	logic flush_q;
	lc3b_word branch_pc_q;
	logic branch_wrong;

	// Retire whenever the head is ready, except in the flush cycle.
	assign ret.pop = ret.head_valid && !flush_q;
	assign ret.commit_we = ret.pop && writes_reg(ret.opcode);

	// Bit 0 of a branch value holds the actual outcome.
	assign branch_wrong = ret.pop && (ret.opcode == op_br) && (ret.predict != ret.value[0]);

	// One-cycle flush pulse after a wrong branch retires.
	always_ff @(posedge clk)
	begin
		if (rst)
			flush_q <= 1'b0;
		else
			flush_q <= branch_wrong;
	end

	// Branch pc held for the pulse.
	always_ff @(posedge clk)
	begin
		if (branch_wrong)
			branch_pc_q <= ret.pc;
	end

	assign ret.flush = flush_q;
	assign mispredict = flush_q;
	assign mispredict_pc = branch_pc_q;

endmodule

// ==== logic/rename_regfile.sv ====
module rename_regfile #(parameter int rob_tag_width = rob_pkg::ROB_TAG_WIDTH_DEF)
(
	input logic clk,
	input logic rst,
	dispatch_if.rename disp,
	retire_if.rename ret,
	lookup_if.rename lkp,
	input rob_pkg::lc3b_reg disp_sr1,
	input rob_pkg::lc3b_reg disp_sr2,
	output rob_pkg::lc3b_word sr1_value,
	output logic sr1_ready,
	output logic [rob_tag_width-1:0] sr1_tag,
	output rob_pkg::lc3b_word sr2_value,
	output logic sr2_ready,
	output logic [rob_tag_width-1:0] sr2_tag
);
	import rob_pkg::*;

	// Architectural state plus rename info.
	lc3b_word reg_value [8];
	logic [7:0] reg_busy;
	logic [rob_tag_width-1:0] reg_tag [8];

	logic alloc;
	logic owner_match;

	// Same accept rule as the buffer.
	assign alloc = disp.valid && !disp.full && !ret.flush;

	// Retiring entry is still the latest writer.
	assign owner_match = reg_busy[ret.dest] && (reg_tag[ret.dest] == ret.head_tag);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			reg_busy <= '0;
			for (int i = 0; i < 8; i++)
			begin
				reg_value[i] <= '0;
				reg_tag[i] <= '0;
			end
		end
		else if (ret.flush)
			reg_busy <= '0;
		else
		begin
			// Commit first so a new rename of the same reg wins.
			if (ret.commit_we)
			begin
				reg_value[ret.dest] <= ret.value;
				if (owner_match)
					reg_busy[ret.dest] <= 1'b0;
			end
			if (alloc && writes_reg(disp.opcode))
			begin
				reg_busy[disp.dest] <= 1'b1;
				reg_tag[disp.dest] <= disp.tag;
			end
		end
	end

	// Tags for the buffer lookup.
	assign lkp.sr1_tag = reg_tag[disp_sr1];
	assign lkp.sr2_tag = reg_tag[disp_sr2];
	assign sr1_tag = reg_tag[disp_sr1];
	assign sr2_tag = reg_tag[disp_sr2];

	// Busy sources come from the buffer.
	assign sr1_ready = !reg_busy[disp_sr1] || lkp.sr1_valid;
	assign sr1_value = reg_busy[disp_sr1] ? lkp.sr1_value : reg_value[disp_sr1];
	assign sr2_ready = !reg_busy[disp_sr2] || lkp.sr2_valid;
	assign sr2_value = reg_busy[disp_sr2] ? lkp.sr2_value : reg_value[disp_sr2];

endmodule

// ==== logic/rob_unit.sv ====
module rob_unit #(parameter int rob_tag_width = rob_pkg::ROB_TAG_WIDTH_DEF)
(
	input logic clk,
	input logic rst,
	input logic disp_valid,
	input rob_pkg::lc3b_opcode disp_opcode,
	input rob_pkg::lc3b_reg disp_dest,
	input rob_pkg::lc3b_reg disp_sr1,
	input rob_pkg::lc3b_reg disp_sr2,
	input rob_pkg::lc3b_word disp_value,
	input logic disp_predict,
	input rob_pkg::lc3b_word disp_pc,
	input logic cdb_valid,
	input logic [rob_tag_width-1:0] cdb_tag,
	input rob_pkg::lc3b_word cdb_value,
	output logic full,
	output logic [rob_tag_width-1:0] disp_tag,
	output rob_pkg::lc3b_word sr1_value,
	output logic sr1_ready,
	output logic [rob_tag_width-1:0] sr1_tag,
	output rob_pkg::lc3b_word sr2_value,
	output logic sr2_ready,
	output logic [rob_tag_width-1:0] sr2_tag,
	output logic retire_valid,
	output logic retire_we,
	output rob_pkg::lc3b_reg retire_dest,
	output rob_pkg::lc3b_word retire_value,
	output logic mispredict,
	output rob_pkg::lc3b_word mispredict_pc
);

	dispatch_if #(.rob_tag_width(rob_tag_width)) disp_bus ();
	retire_if #(.rob_tag_width(rob_tag_width)) ret_bus ();
	lookup_if #(.rob_tag_width(rob_tag_width)) lkp_bus ();

	// Dispatch fields onto the bundle.
	assign disp_bus.valid = disp_valid;
	assign disp_bus.opcode = disp_opcode;
	assign disp_bus.dest = disp_dest;
	assign disp_bus.value = disp_value;
	assign disp_bus.predict = disp_predict;
	assign disp_bus.pc = disp_pc;
	assign full = disp_bus.full;
	assign disp_tag = disp_bus.tag;

	// Retire view.
	assign retire_valid = ret_bus.pop;
	assign retire_we = ret_bus.commit_we;
	assign retire_dest = ret_bus.dest;
	assign retire_value = ret_bus.value;

	rob_storage #(.rob_tag_width(rob_tag_width)) u_storage (
		.clk(clk), .rst(rst), .disp(disp_bus), .ret(ret_bus), .lkp(lkp_bus),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
	);

	retire_ctrl u_retire (
		.clk(clk), .rst(rst), .ret(ret_bus),
		.mispredict(mispredict), .mispredict_pc(mispredict_pc)
	);

	rename_regfile #(.rob_tag_width(rob_tag_width)) u_regfile (
		.clk(clk), .rst(rst), .disp(disp_bus), .ret(ret_bus), .lkp(lkp_bus),
		.disp_sr1(disp_sr1), .disp_sr2(disp_sr2),
		.sr1_value(sr1_value), .sr1_ready(sr1_ready), .sr1_tag(sr1_tag),
		.sr2_value(sr2_value), .sr2_ready(sr2_ready), .sr2_tag(sr2_tag)
	);

endmodule

// ==== testbench/rob_chk.sv ====
module rob_chk #(parameter int rob_tag_width = rob_pkg::ROB_TAG_WIDTH_DEF)
(
	input logic clk,
	input logic rst,
	input logic flush,
	input logic [rob_tag_width-1:0] head,
	input logic [rob_tag_width-1:0] tail,
	input logic [rob_tag_width:0] count
);
	// Entry count at the count's own width.
	localparam logic [rob_tag_width:0] max_count = {1'b1, {rob_tag_width{1'b0}}};

	logic full;
	// Read back by the testbench at the end of the run.
	int fail_count = 0;

	assign full = (count == max_count);

	// Occupancy bounded by the entry count.
	count_bound: assert property (@(posedge clk) disable iff (rst) count <= max_count)
	else
	begin
		$error("ROB count above entry count");
		fail_count++;
	end

	// Flush restarts both pointers.
	flush_clears: assert property (@(posedge clk) disable iff (rst)
		flush |=> (head == '0) && (tail == '0))
	else
	begin
		$error("ROB pointers not cleared after flush");
		fail_count++;
	end

	// No allocate gets in while full.
	full_holds: assert property (@(posedge clk) disable iff (rst)
		full |=> count <= $past(count))
	else
	begin
		$error("ROB count rose while full");
		fail_count++;
	end

endmodule

bind rob_storage rob_chk #(.rob_tag_width(rob_tag_width)) chk (
	.clk(clk), .rst(rst), .flush(ret.flush), .head(head), .tail(tail), .count(count)
);

// ==== testbench/rob_tb.sv ====
module rob_tb;
	import rob_pkg::*;

	localparam int tag_width = 3;
	localparam int clk_period = 100;
	// About four times the full directed run.
	localparam int watchdog_cycles = 400;

	typedef logic [tag_width-1:0] rob_tag;

	logic clk;
	logic rst;
	logic disp_valid;
	lc3b_opcode disp_opcode;
	lc3b_reg disp_dest;
	lc3b_reg disp_sr1;
	lc3b_reg disp_sr2;
	lc3b_word disp_value;
	logic disp_predict;
	lc3b_word disp_pc;
	logic cdb_valid;
	rob_tag cdb_tag;
	lc3b_word cdb_value;
	logic full;
	rob_tag disp_tag;
	lc3b_word sr1_value;
	logic sr1_ready;
	rob_tag sr1_tag;
	lc3b_word sr2_value;
	logic sr2_ready;
	rob_tag sr2_tag;
	logic retire_valid;
	logic retire_we;
	lc3b_reg retire_dest;
	lc3b_word retire_value;
	logic mispredict;
	lc3b_word mispredict_pc;

	int errors;
	int test_start;
	int tests_passed;
	int tests_failed;
	integer seed;
	// Expected register file and next allocate tag.
	lc3b_word reg_model [8];
	rob_tag next_tag;

	rob_unit #(.rob_tag_width(tag_width)) UUT (.*);

	always #(clk_period / 2) clk = ~clk;

	task automatic log_mismatch(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		$display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
		errors++;
	endtask

	task automatic check_word(input string name, input lc3b_word got, input lc3b_word exp);
		if (got !== exp)
			log_mismatch(name, got, exp);
	endtask

	task automatic check_reg(input string name, input lc3b_reg got, input lc3b_reg exp);
		if (got !== exp)
			log_mismatch(name, 16'(got), 16'(exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			log_mismatch(name, 16'(got), 16'(exp));
	endtask

	task automatic check_tag(input string name, input rob_tag got, input rob_tag exp);
		if (got !== exp)
			log_mismatch(name, 16'(got), 16'(exp));
	endtask

	task automatic end_test(input string name);
		if (errors == test_start)
		begin
			tests_passed++;
			$display("Test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("Test %s: %0d errors", name, errors - test_start);
		end
		test_start = errors;
	endtask

	// Next falling edge, strobes dropped.
	task automatic advance();
		@(negedge clk);
		disp_valid = 1'b0;
		cdb_valid = 1'b0;
	endtask

	// Last drive of a cycle, since it settles and checks the tag.
	task automatic dispatch(input lc3b_opcode op, input lc3b_reg dest, input lc3b_word value,
		input logic predict, input logic accept);
		disp_valid = 1'b1;
		disp_opcode = op;
		disp_dest = dest;
		disp_value = value;
		disp_predict = predict;
		disp_pc = lc3b_word'($random(seed));
		#1;
		check_tag("disp_tag", disp_tag, next_tag);
		if (accept)
			next_tag = next_tag + rob_tag'(1);
	endtask

	task automatic write_result(input rob_tag tag, input lc3b_word value);
		cdb_valid = 1'b1;
		cdb_tag = tag;
		cdb_value = value;
	endtask

	task automatic expect_retire(input lc3b_reg dest, input lc3b_word value, input logic we);
		#1;
		check_bit("retire_valid", retire_valid, 1'b1);
		check_bit("retire_we", retire_we, we);
		check_reg("retire_dest", retire_dest, dest);
		check_word("retire_value", retire_value, value);
		// Register takes the value at this edge.
		if (we)
			reg_model[dest] = value;
	endtask

	task automatic expect_idle();
		#1;
		check_bit("retire_valid", retire_valid, 1'b0);
	endtask

	// One register pair per cycle, all must be ready.
	task automatic scan_regs();
		for (int r = 0; r < 8; r++)
		begin
			advance();
			disp_sr1 = lc3b_reg'(r);
			disp_sr2 = lc3b_reg'(7 - r);
			#1;
			check_word("sr1_value", sr1_value, reg_model[r]);
			check_bit("sr1_ready", sr1_ready, 1'b1);
			check_word("sr2_value", sr2_value, reg_model[7 - r]);
			check_bit("sr2_ready", sr2_ready, 1'b1);
		end
	endtask

	task automatic reset_state();
		#1;
		check_bit("full", full, 1'b0);
		check_bit("retire_valid", retire_valid, 1'b0);
		check_bit("retire_we", retire_we, 1'b0);
		check_bit("mispredict", mispredict, 1'b0);
		check_tag("disp_tag", disp_tag, next_tag);
		scan_regs();
		end_test("reset");
	endtask

	// Results arrive 2, 0, 1 but retire 0, 1, 2.
	task automatic retire_in_order();
		lc3b_word v [3];
		for (int i = 0; i < 3; i++)
		begin
			v[i] = lc3b_word'($random(seed));
			advance();
			dispatch(op_add, lc3b_reg'(i + 1), 16'h0000, 1'b0, 1'b1);
		end
		advance();
		write_result(3'd2, v[2]);
		expect_idle();
		advance();
		write_result(3'd0, v[0]);
		expect_idle();
		advance();
		expect_retire(3'd1, v[0], 1'b1);
		advance();
		write_result(3'd1, v[1]);
		expect_idle();
		advance();
		expect_retire(3'd2, v[1], 1'b1);
		advance();
		expect_retire(3'd3, v[2], 1'b1);
		advance();
		expect_idle();
		end_test("in-order retire");
	endtask

	task automatic resolve_operands();
		lc3b_word w [3];
		rob_tag t;
		for (int i = 0; i < 3; i++)
			w[i] = lc3b_word'($random(seed));
		t = next_tag;
		advance();
		disp_sr1 = 3'd3;
		disp_sr2 = 3'd3;
		dispatch(op_add, 3'd3, 16'h0000, 1'b0, 1'b1);
		advance();
		write_result(t, w[0]);
		#1;
		check_bit("sr1_ready", sr1_ready, 1'b0);
		check_tag("sr1_tag", sr1_tag, t);
		check_bit("sr2_ready", sr2_ready, 1'b0);
		check_tag("sr2_tag", sr2_tag, t);
		// Ready from the buffer while retiring.
		advance();
		expect_retire(3'd3, w[0], 1'b1);
		check_bit("sr1_ready", sr1_ready, 1'b1);
		check_word("sr1_value", sr1_value, w[0]);
		check_word("sr2_value", sr2_value, w[0]);
		// Now from the file.
		advance();
		dispatch(op_add, 3'd3, 16'h0000, 1'b0, 1'b1);
		check_bit("sr1_ready", sr1_ready, 1'b1);
		check_word("sr1_value", sr1_value, w[0]);
		// Second writer in flight before the first retires.
		advance();
		write_result(t + rob_tag'(1), w[1]);
		dispatch(op_add, 3'd3, 16'h0000, 1'b0, 1'b1);
		check_bit("sr1_ready", sr1_ready, 1'b0);
		check_tag("sr1_tag", sr1_tag, t + rob_tag'(1));
		check_tag("sr2_tag", sr2_tag, t + rob_tag'(1));
		advance();
		expect_retire(3'd3, w[1], 1'b1);
		check_bit("sr1_ready", sr1_ready, 1'b0);
		check_tag("sr1_tag", sr1_tag, t + rob_tag'(2));
		advance();
		write_result(t + rob_tag'(2), w[2]);
		#1;
		check_bit("sr1_ready", sr1_ready, 1'b0);
		advance();
		expect_retire(3'd3, w[2], 1'b1);
		advance();
		#1;
		check_bit("sr1_ready", sr1_ready, 1'b1);
		check_word("sr1_value", sr1_value, w[2]);
		end_test("operand resolution");
	endtask

	task automatic fill_to_capacity();
		lc3b_word vals [8];
		rob_tag first;
		first = next_tag;
		for (int i = 0; i < 8; i++)
		begin
			advance();
			dispatch(op_add, 3'd5, 16'h0000, 1'b0, 1'b1);
			check_bit("full", full, 1'b0);
		end
		// Ninth dispatch is dropped.
		advance();
		dispatch(op_add, 3'd6, 16'h0000, 1'b0, 1'b0);
		check_bit("full", full, 1'b1);
		advance();
		vals[0] = lc3b_word'($random(seed));
		write_result(first, vals[0]);
		#1;
		check_tag("disp_tag", disp_tag, first);
		check_bit("full", full, 1'b1);
		// Each result retires the cycle after its write.
		for (int i = 1; i <= 8; i++)
		begin
			advance();
			if (i < 8)
			begin
				vals[i] = lc3b_word'($random(seed));
				write_result(first + rob_tag'(i), vals[i]);
			end
			expect_retire(3'd5, vals[i - 1], 1'b1);
			if (i <= 2)
				check_bit("full", full, i == 1);
		end
		advance();
		expect_idle();
		scan_regs();
		end_test("capacity");
	endtask

	task automatic flush_on_mispredict();
		lc3b_word branch_pc;
		rob_tag add_tag;
		// Predicted taken, actually not taken.
		advance();
		dispatch(op_br, 3'd0, 16'h0000, 1'b1, 1'b1);
		branch_pc = disp_pc;
		// Add result lands with its allocate, so the add heads the flush cycle.
		advance();
		add_tag = next_tag;
		write_result(add_tag, lc3b_word'($random(seed)));
		dispatch(op_add, 3'd2, 16'h0000, 1'b0, 1'b1);
		expect_retire(3'd0, 16'h0000, 1'b0);
		check_bit("mispredict", mispredict, 1'b0);
		// Flush cycle, the ready add and a new dispatch are both ignored.
		advance();
		dispatch(op_add, 3'd4, 16'h0000, 1'b0, 1'b0);
		check_bit("mispredict", mispredict, 1'b1);
		check_word("mispredict_pc", mispredict_pc, branch_pc);
		check_bit("retire_valid", retire_valid, 1'b0);
		next_tag = '0;
		advance();
		#1;
		check_bit("mispredict", mispredict, 1'b0);
		check_tag("disp_tag", disp_tag, next_tag);
		check_bit("full", full, 1'b0);
		repeat (2)
		begin
			advance();
			expect_idle();
		end
		scan_regs();
		end_test("branch mispredict");
	endtask

	task automatic retire_non_writing();
		lc3b_word v;
		v = lc3b_word'($random(seed));
		advance();
		dispatch(op_br, 3'd1, 16'h0001, 1'b1, 1'b1);
		advance();
		dispatch(op_str, 3'd4, v, 1'b0, 1'b1);
		expect_retire(3'd1, 16'h0001, 1'b0);
		advance();
		expect_retire(3'd4, v, 1'b0);
		check_bit("mispredict", mispredict, 1'b0);
		advance();
		expect_idle();
		check_bit("mispredict", mispredict, 1'b0);
		scan_regs();
		end_test("non-writing ops");
	endtask

	// Stalled run ends here.
	initial
	begin
		#(watchdog_cycles * clk_period);
		$display("Watchdog expired, tests did not finish within %0d cycles", watchdog_cycles);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		seed = 19;
		errors = 0;
		test_start = 0;
		tests_passed = 0;
		tests_failed = 0;
		next_tag = '0;
		clk = 1'b0;
		rst = 1'b1;
		disp_valid = 1'b0;
		disp_opcode = op_br;
		disp_dest = '0;
		disp_sr1 = '0;
		disp_sr2 = '0;
		disp_value = '0;
		disp_predict = 1'b0;
		disp_pc = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_value = '0;
		for (int r = 0; r < 8; r++)
			reg_model[r] = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		reset_state();
		retire_in_order();
		resolve_operands();
		fill_to_capacity();
		retire_non_writing();
		flush_on_mispredict();
		// Bound assertion failures count too.
		errors = errors + UUT.u_storage.chk.fail_count;
		$display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
			tests_passed, tests_failed, UUT.u_storage.chk.fail_count);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== rob_core.f ====
logic/rob_pkg.sv
logic/rob_ifs.sv
logic/rob_storage.sv
logic/retire_ctrl.sv
logic/rename_regfile.sv
logic/rob_unit.sv
testbench/rob_chk.sv
testbench/rob_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module rob_tb -f rob_core.f -o rob_sim
out=$(./obj_dir/rob_sim +verilator+error+limit+100)
echo "$out"
if echo "$out" | grep -qx "Simulation passed"
then
	exit 0
fi
exit 1
